// File: hw/dma_rd_pkg.sv
// ##################################################
// Shared widths, encodings and payload structs of the
// DMA read engine, imported by every module header
// ##################################################
package dma_rd_pkg;

    // Bus geometry
    localparam int ADDR_W         = 32;
    localparam int DATA_W         = 32;
    localparam int BYTES_PER_BEAT = DATA_W / 8;
    localparam int BEAT_SHIFT     = $clog2(BYTES_PER_BEAT);
    localparam int AXI_LEN_W      = 8;
    localparam int MAX_BEATS      = 256;
    localparam int BYTE_LEN_W     = 11;

    // Buffering in the result block
    localparam int FIFO_DEPTH = 8;
    localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
    localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);
    localparam int STAT_DEPTH = 2;

    // No burst may cross this boundary
    localparam int PAGE_BYTES = 4096;
    localparam int PAGE_SHIFT = $clog2(PAGE_BYTES);

    typedef enum logic [1:0] {
        OP_NONE,
        OP_READ_INCR,
        OP_READ_FIXED,
        OP_READ_LOCK
    } rd_op_e;

    // AXI4 encodings
    typedef enum logic [1:0] {
        BURST_FIXED = 2'b00,
        BURST_INCR  = 2'b01
    } axi_burst_e;

    typedef enum logic [1:0] {
        RESP_OKAY,
        RESP_EXOKAY,
        RESP_SLVERR,
        RESP_DECERR
    } axi_resp_e;

    typedef struct packed {
        rd_op_e                op;
        logic [ADDR_W-1:0]     addr;
        logic [BYTE_LEN_W-1:0] byte_len;
    } rd_cmd_t;

    // Burst context, len is beats minus one
    typedef struct packed {
        logic [ADDR_W-1:0]    addr;
        logic                 fixed;
        logic                 lock;
        logic [AXI_LEN_W-1:0] len;
    } burst_ctx_t;

    typedef struct packed {
        logic [ADDR_W-1:0]    addr;
        logic [AXI_LEN_W-1:0] len;
        logic [2:0]           size;
        axi_burst_e           burst;
        logic                 lock;
    } axi_ar_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        axi_resp_e         resp;
        logic              last;
    } axi_r_t;

    typedef struct packed {
        axi_resp_e resp;
        logic      rejected;
    } rd_status_t;

endpackage

// File: hw/dma_cmd_decode.sv
// ##################################################
// Four-phase command intake with legality checks,
// hands a burst context to execute or posts a reject
// ##################################################
`timescale 1ns/1ps

module dma_cmd_decode import dma_rd_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       i_cmd_req,
    input  rd_cmd_t    i_cmd,
    output logic       o_cmd_ack,
    output logic       o_ctx_valid,
    input  logic       i_ctx_ready,
    output burst_ctx_t o_ctx,
    output logic       o_rej_valid,
    input  logic       i_rej_ready
);

    typedef enum logic [1:0] {IDLE, ACK, WAIT_DROP} state_e;

    state_e                           state;
    rd_cmd_t                          cmd_q;
    logic                             hold_valid;
    logic                             hold_rej;
    burst_ctx_t                       hold_ctx;
    logic                             hold_clr;
    logic [PAGE_SHIFT:0]              page_end;
    logic [BYTE_LEN_W-BEAT_SHIFT-1:0] beats_m1;
    logic                             bad_len;
    logic                             reject;

    // Checks run on the captured command while ack is up
    always_comb begin
        page_end = (PAGE_SHIFT+1)'(cmd_q.addr[PAGE_SHIFT-1:0])
                 + (PAGE_SHIFT+1)'(cmd_q.byte_len);
        beats_m1 = cmd_q.byte_len[BYTE_LEN_W-1:BEAT_SHIFT]
                 - (BYTE_LEN_W-BEAT_SHIFT)'(1);
        // Zero, partial beat or longer than one burst
        bad_len  = (cmd_q.byte_len == '0)
                || (cmd_q.byte_len[BEAT_SHIFT-1:0] != '0)
                || (cmd_q.byte_len > BYTE_LEN_W'(MAX_BEATS * BYTES_PER_BEAT));
        reject   = (cmd_q.op == OP_NONE) || bad_len
                || (page_end > (PAGE_SHIFT+1)'(PAGE_BYTES));
    end

    // Intake FSM, a full holding entry stalls the next ack
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE:      if (i_cmd_req && !hold_valid) state <= ACK;
                ACK:       state <= i_cmd_req ? WAIT_DROP : IDLE;
                WAIT_DROP: if (!i_cmd_req) state <= IDLE;
                default:   state <= IDLE;
            endcase
        end
    end

    assign o_cmd_ack = (state != IDLE);

    // Payload capture, the entry decodes one cycle after ack rises
    always_ff @(posedge clk) begin
        if (state == IDLE && i_cmd_req && !hold_valid) begin
            cmd_q <= i_cmd;
        end
        if (state == ACK) begin
            hold_rej       <= reject;
            hold_ctx.addr  <= cmd_q.addr;
            hold_ctx.fixed <= (cmd_q.op == OP_READ_FIXED);
            hold_ctx.lock  <= (cmd_q.op == OP_READ_LOCK);
            hold_ctx.len   <= beats_m1[AXI_LEN_W-1:0];
        end
    end

    assign hold_clr = (o_ctx_valid && i_ctx_ready) || (o_rej_valid && i_rej_ready);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hold_valid <= 1'b0;
        end else if (state == ACK) begin
            hold_valid <= 1'b1;
        end else if (hold_clr) begin
            hold_valid <= 1'b0;
        end
    end

    // Legal entries go to execute, rejects to the status queue
    assign o_ctx_valid = hold_valid && !hold_rej;
    assign o_rej_valid = hold_valid && hold_rej;
    assign o_ctx       = hold_ctx;

endmodule

// File: hw/axi_rd_exec.sv
// ##################################################
// AXI4 read manager, issues AR early from a one-deep
// context buffer and moves R beats into the result FIFO
// ##################################################
`timescale 1ns/1ps

module axi_rd_exec import dma_rd_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              i_ctx_valid,
    output logic              o_ctx_ready,
    input  burst_ctx_t        i_ctx,
    output logic              o_ar_valid,
    input  logic              i_ar_ready,
    output axi_ar_t           o_ar,
    input  logic              i_r_valid,
    output logic              o_r_ready,
    input  axi_r_t            i_r,
    output logic              o_beat_valid,
    output logic [DATA_W-1:0] o_beat_data,
    input  logic              i_fifo_ready,
    output logic              o_stat_valid,
    output rd_status_t        o_stat,
    input  logic              i_stat_ready
);

    logic       buf_valid;
    burst_ctx_t buf_ctx;
    logic       cur_valid;
    burst_ctx_t cur_ctx;
    logic       ar_sent;
    logic       ctx_pop;
    logic       txn_active;
    logic       r_fire;
    logic       final_beat;
    axi_resp_e  resp_acc;
    axi_resp_e  resp_merged;

    // Buffered entry first, otherwise pass the port straight through
    always_comb begin
        cur_valid = buf_valid || i_ctx_valid;
        cur_ctx   = buf_valid ? buf_ctx : i_ctx;
    end

    assign o_ctx_ready = !buf_valid;

    // AR goes out as soon as a context shows up
    always_comb begin
        o_ar_valid = cur_valid && !ar_sent;
        o_ar.addr  = cur_ctx.addr;
        o_ar.len   = cur_ctx.len;
        o_ar.size  = 3'(BEAT_SHIFT);
        o_ar.burst = cur_ctx.fixed ? BURST_FIXED : BURST_INCR;
        o_ar.lock  = cur_ctx.lock;
    end

    // Context retires into the tracker once AR is done and the
    // previous burst is on its last beat
    assign ctx_pop = cur_valid && (!txn_active || final_beat) && (i_ar_ready || ar_sent);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            buf_valid  <= 1'b0;
            ar_sent    <= 1'b0;
            txn_active <= 1'b0;
        end else begin
            if (ctx_pop) begin
                buf_valid <= 1'b0;
            end else if (i_ctx_valid && o_ctx_ready) begin
                buf_valid <= 1'b1;
            end
            if (ctx_pop) begin
                ar_sent <= 1'b0;
            end else if (o_ar_valid && i_ar_ready) begin
                ar_sent <= 1'b1;
            end
            if (ctx_pop) begin
                txn_active <= 1'b1;
            end else if (final_beat) begin
                txn_active <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_ctx_valid && o_ctx_ready) begin
            buf_ctx <= i_ctx;
        end
    end

    // Last beat also needs a free status slot
    assign o_r_ready    = txn_active && i_fifo_ready && (!i_r.last || i_stat_ready);
    assign r_fire       = i_r_valid && o_r_ready;
    assign final_beat   = r_fire && i_r.last;
    assign o_beat_valid = r_fire;
    assign o_beat_data  = i_r.data;

    // Responses OR together over the burst
    assign resp_merged = axi_resp_e'(resp_acc | i_r.resp);

    always_ff @(posedge clk) begin
        if (ctx_pop) begin
            resp_acc <= RESP_OKAY;
        end else if (r_fire) begin
            resp_acc <= resp_merged;
        end
    end

    assign o_stat_valid    = final_beat;
    assign o_stat.resp     = resp_merged;
    assign o_stat.rejected = 1'b0;

endmodule

// File: hw/rd_result.sv
// ##################################################
// Data FIFO onto the read stream plus a status queue
// that drives the four-phase completion port
// ##################################################
`timescale 1ns/1ps

module rd_result import dma_rd_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              i_beat_valid,
    input  logic [DATA_W-1:0] i_beat_data,
    output logic              o_fifo_ready,
    input  logic              i_stat_valid,
    input  rd_status_t        i_stat,
    output logic              o_stat_ready,
    input  logic              i_rej_valid,
    output logic              o_rej_ready,
    output logic              o_rd_valid,
    input  logic              i_rd_ready,
    output logic [DATA_W-1:0] o_rd_data,
    output logic              o_done_req,
    output rd_status_t        o_done_stat,
    input  logic              i_done_ack
);

    typedef enum logic [1:0] {IDLE, REQ, WAIT_DROP} state_e;

    logic [DATA_W-1:0]     mem [FIFO_DEPTH];
    logic [FIFO_PTR_W-1:0] wr_ptr;
    logic [FIFO_PTR_W-1:0] rd_ptr;
    logic [FIFO_CNT_W-1:0] fifo_cnt;
    logic                  rd_pop;
    logic [STAT_DEPTH-1:0] q_valid;
    logic [STAT_DEPTH-1:0] q_valid_n;
    rd_status_t            q_stat   [STAT_DEPTH];
    rd_status_t            q_stat_n [STAT_DEPTH];
    logic [FIFO_CNT_W-1:0] q_cnt    [STAT_DEPTH];
    logic [FIFO_CNT_W-1:0] q_cnt_n  [STAT_DEPTH];
    logic [FIFO_CNT_W-1:0] open_cnt;
    logic [FIFO_CNT_W-1:0] open_cnt_n;
    logic                  pop_q0;
    logic                  pop_q1;
    logic                  pop_open;
    rd_status_t            push_stat;
    logic [FIFO_CNT_W-1:0] push_cnt;
    logic                  done_take;
    state_e                state;

    // Data FIFO, output comes straight from registers
    always_ff @(posedge clk) begin
        if (i_beat_valid) mem[wr_ptr] <= i_beat_data;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            fifo_cnt <= '0;
        end else begin
            if (i_beat_valid) wr_ptr <= wr_ptr + FIFO_PTR_W'(1);
            if (rd_pop) rd_ptr <= rd_ptr + FIFO_PTR_W'(1);
            fifo_cnt <= fifo_cnt + FIFO_CNT_W'(i_beat_valid) - FIFO_CNT_W'(rd_pop);
        end
    end

    assign o_fifo_ready = (fifo_cnt != FIFO_CNT_W'(FIFO_DEPTH));
    assign o_rd_valid   = (fifo_cnt != '0);
    assign o_rd_data    = mem[rd_ptr];
    assign rd_pop       = o_rd_valid && i_rd_ready;

    // Execute wins the status slot over a reject
    assign o_stat_ready = !q_valid[STAT_DEPTH-1];
    assign o_rej_ready  = !q_valid[STAT_DEPTH-1] && !i_stat_valid;
    assign done_take    = (state == IDLE) && q_valid[0] && (q_cnt[0] == '0);

    always_comb begin
        // Popped beat belongs to the oldest entry still owning beats
        pop_q0     = rd_pop && q_valid[0] && (q_cnt[0] != '0);
        pop_q1     = rd_pop && !pop_q0 && q_valid[1] && (q_cnt[1] != '0);
        pop_open   = rd_pop && !pop_q0 && !pop_q1;
        open_cnt_n = open_cnt + FIFO_CNT_W'(i_beat_valid) - FIFO_CNT_W'(pop_open);
        push_stat  = i_stat_valid ? i_stat : rd_status_t'{resp: RESP_OKAY, rejected: 1'b1};
        push_cnt   = i_stat_valid ? open_cnt_n : '0;
        q_valid_n  = q_valid;
        q_stat_n   = q_stat;
        q_cnt_n    = q_cnt;
        if (pop_q0) q_cnt_n[0] = q_cnt[0] - FIFO_CNT_W'(1);
        if (pop_q1) q_cnt_n[1] = q_cnt[1] - FIFO_CNT_W'(1);
        // Head moves to the completion port, queue shifts down
        if (done_take) begin
            q_valid_n[0] = q_valid_n[1];
            q_stat_n[0]  = q_stat_n[1];
            q_cnt_n[0]   = q_cnt_n[1];
            q_valid_n[1] = 1'b0;
        end
        if ((i_stat_valid && o_stat_ready) || (i_rej_valid && o_rej_ready)) begin
            if (!q_valid_n[0]) begin
                q_valid_n[0] = 1'b1;
                q_stat_n[0]  = push_stat;
                q_cnt_n[0]   = push_cnt;
            end else begin
                q_valid_n[1] = 1'b1;
                q_stat_n[1]  = push_stat;
                q_cnt_n[1]   = push_cnt;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            q_valid  <= '0;
            open_cnt <= '0;
            state    <= IDLE;
        end else begin
            q_valid  <= q_valid_n;
            // Beats of the finished burst now counted on its entry
            open_cnt <= (i_stat_valid && o_stat_ready) ? '0 : open_cnt_n;
            case (state)
                IDLE:      if (done_take) state <= REQ;
                REQ:       if (i_done_ack) state <= WAIT_DROP;
                WAIT_DROP: if (!i_done_ack) state <= IDLE;
                default:   state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        q_stat <= q_stat_n;
        q_cnt  <= q_cnt_n;
        if (done_take) o_done_stat <= q_stat[0];
    end

    assign o_done_req = (state == REQ);

endmodule

// File: hw/dma_rd_top.sv
// ##################################################
// DMA read engine top, decode feeds execute and both
// report into result; AXI read, stream and handshakes
// ##################################################
`timescale 1ns/1ps

module dma_rd_top import dma_rd_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    // Command port
    input  logic              i_cmd_req,
    input  rd_cmd_t           i_cmd,
    output logic              o_cmd_ack,
    // AXI read manager
    output logic              o_ar_valid,
    input  logic              i_ar_ready,
    output axi_ar_t           o_ar,
    input  logic              i_r_valid,
    output logic              o_r_ready,
    input  axi_r_t            i_r,
    // Data stream
    output logic              o_rd_valid,
    input  logic              i_rd_ready,
    output logic [DATA_W-1:0] o_rd_data,
    // Completion port
    output logic              o_done_req,
    output rd_status_t        o_done_stat,
    input  logic              i_done_ack
);

    logic              ctx_valid;
    logic              ctx_ready;
    burst_ctx_t        ctx;
    logic              rej_valid;
    logic              rej_ready;
    logic              beat_valid;
    logic [DATA_W-1:0] beat_data;
    logic              fifo_ready;
    logic              stat_valid;
    rd_status_t        stat;
    logic              stat_ready;

    dma_cmd_decode u_decode (
        .clk, .rst_n,
        .i_cmd_req, .i_cmd, .o_cmd_ack,
        .o_ctx_valid (ctx_valid), .i_ctx_ready (ctx_ready), .o_ctx (ctx),
        .o_rej_valid (rej_valid), .i_rej_ready (rej_ready)
    );

    axi_rd_exec u_exec (
        .clk, .rst_n,
        .i_ctx_valid (ctx_valid), .o_ctx_ready (ctx_ready), .i_ctx (ctx),
        .o_ar_valid, .i_ar_ready, .o_ar,
        .i_r_valid, .o_r_ready, .i_r,
        .o_beat_valid (beat_valid), .o_beat_data (beat_data), .i_fifo_ready (fifo_ready),
        .o_stat_valid (stat_valid), .o_stat (stat), .i_stat_ready (stat_ready)
    );

    rd_result u_result (
        .clk, .rst_n,
        .i_beat_valid (beat_valid), .i_beat_data (beat_data), .o_fifo_ready (fifo_ready),
        .i_stat_valid (stat_valid), .i_stat (stat), .o_stat_ready (stat_ready),
        .i_rej_valid (rej_valid), .o_rej_ready (rej_ready),
        .o_rd_valid, .i_rd_ready, .o_rd_data,
        .o_done_req, .o_done_stat, .i_done_ack
    );

endmodule

// File: sim/axi_mem_model.sv
// ##################################################
// AXI4 read subordinate for the testbench, one burst
// at a time with random AR/R back-pressure
// ##################################################
`timescale 1ns/1ps

module axi_mem_model import dma_rd_pkg::*; #(
    parameter logic [31:0] SEED = 32'h38d3235b
) (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    i_ar_valid,
    output logic    o_ar_ready,
    input  axi_ar_t i_ar,
    output logic    o_r_valid,
    input  logic    i_r_ready,
    output axi_r_t  o_r
);

    integer               seed = SEED;
    logic [31:0]          rnd;
    logic                 busy;
    logic                 fixed;
    logic [ADDR_W-1:0]    cur_addr;
    logic [AXI_LEN_W-1:0] left;

    // Data is the address with a fixed pattern, SLVERR in 0x3000..0x30FF
    always_comb begin
        o_r.data = cur_addr ^ 32'hA5A5_0000;
        o_r.resp = (cur_addr[ADDR_W-1:8] == 24'h30) ? RESP_SLVERR : RESP_OKAY;
        o_r.last = (left == '0);
    end

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_ar_ready <= 1'b0;
            o_r_valid  <= 1'b0;
            busy       <= 1'b0;
            fixed      <= 1'b0;
            cur_addr   <= '0;
            left       <= '0;
        end else begin
            rnd = $random(seed);
            // New AR only between bursts
            o_ar_ready <= !busy && !(i_ar_valid && o_ar_ready) && rnd[0];
            if (i_ar_valid && o_ar_ready) begin
                busy     <= 1'b1;
                cur_addr <= i_ar.addr;
                left     <= i_ar.len;
                fixed    <= (i_ar.burst == BURST_FIXED);
            end
            if (o_r_valid && i_r_ready) begin
                if (o_r.last) begin
                    busy      <= 1'b0;
                    o_r_valid <= 1'b0;
                end else begin
                    left      <= left - AXI_LEN_W'(1);
                    o_r_valid <= rnd[1];
                    if (!fixed) cur_addr <= cur_addr + ADDR_W'(BYTES_PER_BEAT);
                end
            end else if (busy && !o_r_valid) begin
                o_r_valid <= rnd[1];
            end
        end
    end

endmodule

// File: sim/tb_dma_rd.sv
// ##################################################
// Directed regression of the DMA read engine against
// the AXI memory model, run as top tb_dma_rd
// ##################################################
`timescale 1ns/1ps

module tb_dma_rd import dma_rd_pkg::*; ();

    localparam logic [31:0] SEED = 32'h38d3235b;
    // Beats over all tests: 16 + 8 + 4 + 16 + 28
    localparam int TOTAL_BEATS    = 72;
    localparam int TIMEOUT_CYCLES = 200 * TOTAL_BEATS + 2000;

    logic              clk = 1'b0;
    logic              rst_n;
    logic              i_cmd_req;
    rd_cmd_t           i_cmd;
    logic              o_cmd_ack;
    logic              ar_valid;
    logic              ar_ready;
    axi_ar_t           ar;
    logic              r_valid;
    logic              r_ready;
    axi_r_t            r;
    logic              o_rd_valid;
    logic              i_rd_ready = 1'b0;
    logic [DATA_W-1:0] o_rd_data;
    logic              o_done_req;
    rd_status_t        o_done_stat;
    logic              i_done_ack = 1'b0;

    integer            seed = SEED;
    logic [31:0]       rnd;
    logic              hold_rd;
    logic [DATA_W-1:0] rx_q [$];
    axi_ar_t           ar_q [$];
    rd_status_t        done_q [$];
    int                done_words [$];
    string             test_name;
    int                errors;
    int                test_errors;
    int                tests_run;
    int                tests_failed;

    dma_rd_top u_dut (
        .clk, .rst_n,
        .i_cmd_req, .i_cmd, .o_cmd_ack,
        .o_ar_valid (ar_valid), .i_ar_ready (ar_ready), .o_ar (ar),
        .i_r_valid (r_valid), .o_r_ready (r_ready), .i_r (r),
        .o_rd_valid, .i_rd_ready, .o_rd_data,
        .o_done_req, .o_done_stat, .i_done_ack
    );

    axi_mem_model #(.SEED (SEED)) u_mem (
        .clk, .rst_n,
        .i_ar_valid (ar_valid), .o_ar_ready (ar_ready), .i_ar (ar),
        .o_r_valid (r_valid), .i_r_ready (r_ready), .o_r (r)
    );

    always #10 clk = ~clk;

    // Stream sink, AR monitor and completion responder
    always @(posedge clk) begin
        rnd = $random(seed);
        i_rd_ready <= !hold_rd && (rnd[0] || rnd[1]);
        if (rst_n && o_rd_valid && i_rd_ready) rx_q.push_back(o_rd_data);
        if (rst_n && ar_valid && ar_ready) ar_q.push_back(ar);
        if (rst_n && o_done_req && !i_done_ack) begin
            done_q.push_back(o_done_stat);
            done_words.push_back(rx_q.size());
            i_done_ack <= 1'b1;
        end else if (!o_done_req && i_done_ack) begin
            i_done_ack <= 1'b0;
        end
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("Timeout: tests still running after %0d clock cycles", TIMEOUT_CYCLES);
        $display("Regression failed");
        $finish;
    end

    function automatic logic [31:0] exp_word(input logic [31:0] addr);
        return addr ^ 32'hA5A5_0000;
    endfunction

    // Any beat inside the error window makes the burst SLVERR
    function automatic axi_resp_e exp_resp(input logic [31:0] addr, input int beats,
                                           input logic fixed);
        axi_resp_e   resp;
        logic [31:0] a;
        resp = RESP_OKAY;
        for (int i = 0; i < beats; i++) begin
            a = fixed ? addr : addr + 32'(i * 4);
            if (a >= 32'h3000 && a <= 32'h30FF) resp = RESP_SLVERR;
        end
        return resp;
    endfunction

    task automatic check_val(input string what, input logic [31:0] exp, input logic [31:0] act);
        assert (act == exp) else begin
            $display("[FAIL] %s: %s expected %h actual %h", test_name, what, exp, act);
            errors++;
        end
    endtask

    task automatic check_true(input logic ok, input string msg);
        assert (ok) else begin
            $display("[FAIL] %s: %s", test_name, msg);
            errors++;
        end
    endtask

    task automatic clear_queues();
        rx_q.delete();
        ar_q.delete();
        done_q.delete();
        done_words.delete();
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = errors;
        clear_queues();
    endtask

    task automatic end_test();
        tests_run++;
        if (errors == test_errors) begin
            $display("PASS  %s", test_name);
        end else begin
            tests_failed++;
            $display("FAIL  %s with %0d errors", test_name, errors - test_errors);
        end
    endtask

    // Four-phase command handshake
    task automatic send_cmd(input rd_op_e op, input logic [31:0] addr,
                            input logic [BYTE_LEN_W-1:0] len);
        @(posedge clk);
        i_cmd     <= rd_cmd_t'{op: op, addr: addr, byte_len: len};
        i_cmd_req <= 1'b1;
        do @(posedge clk); while (!o_cmd_ack);
        i_cmd_req <= 1'b0;
        do @(posedge clk); while (o_cmd_ack);
    endtask

    task automatic wait_done(input int n);
        while (done_q.size() < n) @(posedge clk);
    endtask

    // One legal burst, checked word by word plus AR and status
    task automatic run_burst(input rd_op_e op, input logic [31:0] addr, input int beats);
        logic        fixed;
        logic [31:0] a;
        fixed = (op == OP_READ_FIXED);
        clear_queues();
        send_cmd(op, addr, BYTE_LEN_W'(beats * 4));
        wait_done(1);
        check_val("word count", beats, rx_q.size());
        for (int i = 0; i < beats && i < rx_q.size(); i++) begin
            a = fixed ? addr : addr + 32'(i * 4);
            check_val($sformatf("word %0d", i), exp_word(a), rx_q[i]);
        end
        check_val("AR count", 1, ar_q.size());
        if (ar_q.size() > 0) begin
            check_val("AR addr", addr, ar_q[0].addr);
            check_val("AR len", beats - 1, 32'(ar_q[0].len));
            check_val("AR size", 2, 32'(ar_q[0].size));
            check_val("AR burst", fixed ? 0 : 1, 32'(ar_q[0].burst));
            check_val("AR lock", (op == OP_READ_LOCK) ? 1 : 0, 32'(ar_q[0].lock));
        end
        check_val("resp", 32'(exp_resp(addr, beats, fixed)), 32'(done_q[0].resp));
        check_val("rejected", 0, 32'(done_q[0].rejected));
    endtask

    task automatic run_reject(input rd_op_e op, input logic [31:0] addr,
                              input logic [BYTE_LEN_W-1:0] len);
        clear_queues();
        send_cmd(op, addr, len);
        wait_done(1);
        // Quiet period to catch a stray AR or data word
        repeat (20) @(posedge clk);
        check_val("completions", 1, done_q.size());
        check_val("rejected", 1, 32'(done_q[0].rejected));
        check_val("AR count", 0, ar_q.size());
        check_val("word count", 0, rx_q.size());
    endtask

    task automatic incr_read();
        start_test("incr_16_beats");
        run_burst(OP_READ_INCR, 32'h0000_0100, 16);
        end_test();
    endtask

    task automatic fixed_lock_read();
        start_test("fixed_and_lock");
        run_burst(OP_READ_FIXED, 32'h0000_0200, 8);
        run_burst(OP_READ_LOCK, 32'h0000_0400, 4);
        end_test();
    endtask

    task automatic slverr_merge();
        start_test("slverr_merge");
        // First four beats fall in the error window
        run_burst(OP_READ_INCR, 32'h0000_30F0, 16);
        end_test();
    endtask

    task automatic illegal_reject();
        start_test("reject");
        run_reject(OP_READ_INCR, 32'h0000_0FF0, 11'd32);
        run_reject(OP_READ_INCR, 32'h0000_0000, 11'd0);
        run_reject(OP_READ_INCR, 32'h0000_0000, 11'd6);
        run_reject(OP_NONE, 32'h0000_0000, 11'd16);
        end_test();
    endtask

    // Two commands overlap while the stream is stalled
    task automatic backpressure_overlap();
        start_test("backpressure_overlap");
        @(posedge clk);
        hold_rd <= 1'b1;
        send_cmd(OP_READ_INCR, 32'h0000_0500, 11'd64);
        send_cmd(OP_READ_INCR, 32'h0000_0600, 11'd48);
        repeat (100) @(posedge clk);
        // Full FIFO waits on the stream and holds off R
        check_val("stream valid while stalled", 1, 32'(o_rd_valid));
        check_val("R ready with FIFO full", 0, 32'(r_ready));
        check_val("completions while stalled", 0, done_q.size());
        hold_rd <= 1'b0;
        wait_done(2);
        check_val("word count", 28, rx_q.size());
        for (int i = 0; i < 28 && i < rx_q.size(); i++) begin
            check_val($sformatf("word %0d", i),
                      exp_word(i < 16 ? 32'h500 + 32'(i * 4) : 32'h600 + 32'(i * 4 - 64)),
                      rx_q[i]);
        end
        check_true(done_words[0] >= 16, "first completion came before its last word");
        check_val("words at second completion", 28, done_words[1]);
        for (int i = 0; i < 2; i++) begin
            check_val($sformatf("resp %0d", i), 32'(RESP_OKAY), 32'(done_q[i].resp));
            check_val($sformatf("rejected %0d", i), 0, 32'(done_q[i].rejected));
        end
        end_test();
    endtask

    initial begin
        rst_n        = 1'b0;
        i_cmd_req    = 1'b0;
        i_cmd        = '0;
        hold_rd      = 1'b0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        repeat (2) @(posedge clk);
        incr_read();
        fixed_lock_read();
        slverr_merge();
        illegal_reject();
        backpressure_overlap();
        $display("Summary: %0d tests, %0d passed, %0d failed, %0d check errors",
                 tests_run, tests_run - tests_failed, tests_failed, errors);
        if (tests_failed == 0 && errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: dma_rd.f
hw/dma_rd_pkg.sv
hw/dma_cmd_decode.sv
hw/axi_rd_exec.sv
hw/rd_result.sv
hw/dma_rd_top.sv
sim/axi_mem_model.sv
sim/tb_dma_rd.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_dma_rd
FILELIST  = dma_rd.f
OBJ_DIR   = obj_dir
PASS_MSG  = Regression passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the regression"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
